/* tests/fifo_patterns.txt */
// columns: capacity, word count, read percent, first data word, flush flag (all hex)
// read percent 64 checks bypass latency, 0 fills to full, others mix; zeros end the list
// bypass latency, the second row wraps the data values
0020 0010 64 00000100 0
0004 0008 64 fffffffa 0
// reads held off until full, then drained
0010 0020 00 10000000 0
0007 0018 00 11000000 0
0021 0040 00 12000000 0
0001 0010 00 13000000 0
// random read rates
0040 0080 32 20000000 0
0100 00c8 19 21000000 0
0009 0040 50 22000000 0
// random read rates with a flush halfway
0020 0064 4b 30000000 1
0200 0100 3c 31000000 1
0003 0020 5a 32000000 1
0000 0000 00 00000000 0

/* files.f */
design/ram_fifo_pkg.sv
design/stage_in_buffer.sv
design/stage_out_buffer.sv
design/ram_pointer_ctrl.sv
design/spram_model.sv
design/ram_fifo_top.sv
tests/tb_ram_fifo.sv

/* run_sim.sh */
#!/bin/sh
# build and run the FIFO testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_ram_fifo -Mdir obj_dir -o sim_ram_fifo
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_ram_fifo > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

/* tests/tb_ram_fifo.sv */
// self-checking testbench for the RAM backed FIFO
// run from the project root, tests come from tests/fifo_patterns.txt
`timescale 1ns/1ps

module tb_ram_fifo;
    import ram_fifo_pkg::*;

    localparam int MAX_TESTS = 32;
    localparam int COLS      = 5;

    logic              clk;
    logic              rst_n;
    logic              flush;
    logic [CAP_W-1:0]  capacity;
    logic              valid_in;
    logic [DATA_W-1:0] data_in;
    logic              full;
    logic              rd_en;
    logic [DATA_W-1:0] data_out;
    logic              empty;
    logic [CAP_W-1:0]  count;
    logic              panic;

    logic [31:0]       patterns [MAX_TESTS*COLS];
    logic [DATA_W-1:0] expected_q [$];
    integer            seed;
    int                occupancy;
    int                pair_cap;
    logic              accepted;
    logic              popped;
    longint            watchdog_ns;

    ram_fifo_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .capacity (capacity),
        .valid_in (valid_in),
        .data_in  (data_in),
        .full     (full),
        .rd_en    (rd_en),
        .data_out (data_out),
        .empty    (empty),
        .count    (count),
        .panic    (panic)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at time %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at time %0t: %s is %0h, expected %0h",
                                $time, name, actual, expected));
        end
    endtask

    // drive on the rising edge, look at the outputs mid cycle
    // occupancy then already counts the transfers of the coming edge
    task automatic step_cycle(input logic v, input logic [DATA_W-1:0] d, input logic r);
        logic [DATA_W-1:0] want;
        @(posedge clk);
        valid_in <= v;
        data_in  <= d;
        rd_en    <= r;
        @(negedge clk);
        popped   = rd_en && !empty;
        accepted = valid_in && !full;
        if (popped) begin
            if (expected_q.size() == 0) begin
                abort_run($sformatf("word %0h came out at time %0t with none outstanding",
                                    data_out, $time));
            end
            want = expected_q.pop_front();
            check_value("data_out", data_out, want);
            occupancy--;
        end
        if (accepted) begin
            expected_q.push_back(data_in);
            occupancy++;
        end
    endtask

    // new capacity goes in together with the flush
    task automatic flush_and_configure(input int cap);
        @(posedge clk);
        capacity <= CAP_W'(cap);
        flush    <= 1'b1;
        valid_in <= 1'b0;
        rd_en    <= 1'b0;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check_value("empty", empty, 1'b1);
        check_value("data_out", data_out, '0);
        check_value("count", count, '0);
        check_value("full", full, 1'b0);
        check_value("panic", panic, 1'b0);
        expected_q.delete();
        occupancy = 0;
        pair_cap  = (cap + 1) / 2;
    endtask

    task automatic latency_test(input int words, input logic [DATA_W-1:0] first);
        for (int i = 0; i < words; i++) begin
            step_cycle(1'b1, first + DATA_W'(i), 1'b1);
            if (!accepted) begin
                abort_run("an idle FIFO refused a word in the bypass test");
            end
            // accepting edge puts the word into staging
            step_cycle(1'b0, '0, 1'b1);
            check_value("empty", empty, 1'b1);
            // bypass edge moves it to the output buffer, popped here
            step_cycle(1'b0, '0, 1'b1);
            check_value("empty", empty, 1'b0);
            step_cycle(1'b0, '0, 1'b1);
        end
        check_value("panic", panic, 1'b0);
    endtask

    task automatic backpressure_test(input int cap, input int words,
                                     input logic [DATA_W-1:0] first);
        int   sent;
        logic full_seen;
        sent      = 0;
        full_seen = 1'b0;
        while (!full_seen && sent < words) begin
            // idle cycles let pairs settle so full is final before the offer
            repeat (3) step_cycle(1'b0, '0, 1'b0);
            if (full) begin
                full_seen = 1'b1;
            end else begin
                step_cycle(1'b1, first + DATA_W'(sent), 1'b0);
                if (!accepted) begin
                    abort_run("a word was refused while full was low");
                end
                sent++;
            end
        end
        if (!full_seen) begin
            abort_run("full never rose with reads held off");
        end
        if (sent < cap || sent > 2 * pair_cap + 12) begin
            abort_run($sformatf("%0d words accepted before full with capacity %0d",
                                sent, cap));
        end
        check_value("panic", panic, 1'b0);
        // an offer while full is refused and raises panic
        step_cycle(1'b1, first + DATA_W'(sent), 1'b0);
        if (accepted) begin
            abort_run("a word was taken while full was high");
        end
        step_cycle(1'b0, '0, 1'b0);
        check_value("panic", panic, 1'b1);
        while (expected_q.size() != 0) begin
            step_cycle(1'b0, '0, 1'b1);
        end
        repeat (2) step_cycle(1'b0, '0, 1'b0);
        check_value("count", count, '0);
        check_value("empty", empty, 1'b1);
    endtask

    task automatic mixed_rate_test(input int cap, input int words, input int pct,
                                   input logic [DATA_W-1:0] first, input logic do_flush);
        int                sent;
        logic              flushed;
        logic              offer;
        logic              read;
        logic [DATA_W-1:0] next_data;
        sent      = 0;
        flushed   = 1'b0;
        next_data = first;
        while (sent < words || expected_q.size() != 0) begin
            if (do_flush && !flushed && sent == words / 2) begin
                flush_and_configure(cap);
                flushed   = 1'b1;
                next_data = first + 32'h0001_0000;
            end
            // below twice the pair capacity full cannot rise next cycle
            offer = (sent < words) && (occupancy < 2 * pair_cap);
            read  = ($unsigned($random(seed)) % 100) < pct;
            step_cycle(offer, next_data, read);
            if (accepted) begin
                sent++;
                next_data++;
            end
        end
        repeat (2) step_cycle(1'b0, '0, 1'b0);
        check_value("count", count, '0);
        check_value("empty", empty, 1'b1);
        check_value("panic", panic, 1'b0);
    endtask

    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        abort_run($sformatf("timeout: tests did not finish within %0d ns", watchdog_ns));
    end

    initial begin
        int                num_tests;
        int                total_words;
        int                idx;
        logic [DATA_W-1:0] first;
        seed        = 32'h51dbe334;
        rst_n       = 1'b0;
        flush       = 1'b0;
        capacity    = CAP_W'(32);
        valid_in    = 1'b0;
        data_in     = '0;
        rd_en       = 1'b0;
        accepted    = 1'b0;
        popped      = 1'b0;
        occupancy   = 0;
        pair_cap    = 0;
        watchdog_ns = 0;
        $readmemh("tests/fifo_patterns.txt", patterns);
        num_tests   = 0;
        total_words = 0;
        // a row with capacity zero ends the list
        while (num_tests < MAX_TESTS && patterns[num_tests*COLS] != 0) begin
            total_words += patterns[num_tests*COLS+1];
            num_tests++;
        end
        if (num_tests == 0) begin
            abort_run("no tests could be read from tests/fifo_patterns.txt");
        end
        watchdog_ns = 4 * (20 * longint'(total_words) + 200);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("empty", empty, 1'b1);
        check_value("full", full, 1'b0);
        check_value("count", count, '0);
        check_value("panic", panic, 1'b0);
        for (int t = 0; t < num_tests; t++) begin
            idx   = t * COLS;
            first = patterns[idx+3];
            flush_and_configure(patterns[idx]);
            if (patterns[idx+2] >= 100) begin
                latency_test(patterns[idx+1], first);
            end else if (patterns[idx+2] == 0) begin
                backpressure_test(patterns[idx], patterns[idx+1], first);
            end else begin
                mixed_rate_test(patterns[idx], patterns[idx+1], patterns[idx+2], first,
                                patterns[idx+4][0]);
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* design/ram_fifo_top.sv */
// deep word FIFO with pairs of words kept in a single-port RAM
// full already covers the capacity limit, offering while full sets panic
`timescale 1ns/1ps

module ram_fifo_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             flush,
    input  logic [ram_fifo_pkg::CAP_W-1:0]   capacity,
    input  logic                             valid_in,
    input  logic [ram_fifo_pkg::DATA_W-1:0]  data_in,
    output logic                             full,
    input  logic                             rd_en,
    output logic [ram_fifo_pkg::DATA_W-1:0]  data_out,
    output logic                             empty,
    output logic [ram_fifo_pkg::CAP_W-1:0]   count,
    output logic                             panic
);
    import ram_fifo_pkg::*;

    logic                   push;
    logic                   offer_refused;
    logic                   in_full;
    logic                   ram_full;
    logic                   bypass_pop;
    logic                   pair_pop;
    logic                   pair_load;
    logic [STAGE_LVL_W-1:0] stage_level;
    logic [OUT_LVL_W-1:0]   out_level;
    pair_word_t             oldest_pair;
    pair_word_t             rdata;
    ram_req_t               ram_req;

    assign full          = in_full || ram_full;
    assign push          = valid_in && !full;
    assign offer_refused = valid_in && full;

    stage_in_buffer u_stage_in (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .push        (push),
        .push_data   (data_in),
        .bypass_pop  (bypass_pop),
        .pair_pop    (pair_pop),
        .oldest_pair (oldest_pair),
        .level       (stage_level),
        .in_full     (in_full)
    );

    // bypass word is the staged head, taken in the same cycle it is popped
    stage_out_buffer u_stage_out (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .bypass_load (bypass_pop),
        .bypass_data (oldest_pair.lo),
        .pair_load   (pair_load),
        .pair_data   (rdata),
        .rd_en       (rd_en),
        .data_out    (data_out),
        .level       (out_level),
        .empty       (empty)
    );

    ram_pointer_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .capacity      (capacity),
        .stage_level   (stage_level),
        .out_level     (out_level),
        .oldest_pair   (oldest_pair),
        .offer_refused (offer_refused),
        .bypass_pop    (bypass_pop),
        .pair_pop      (pair_pop),
        .pair_load     (pair_load),
        .ram_req       (ram_req),
        .count         (count),
        .ram_full      (ram_full),
        .panic         (panic)
    );

    spram_model u_ram (
        .clk     (clk),
        .ram_req (ram_req),
        .rdata   (rdata)
    );

endmodule

/* design/spram_model.sv */
// behavioral single-port RAM of pair words, one cycle read latency
// enables are active low, rdata holds its value between reads
`timescale 1ns/1ps

module spram_model (
    input  logic                     clk,
    input  ram_fifo_pkg::ram_req_t   ram_req,
    output ram_fifo_pkg::pair_word_t rdata
);
    import ram_fifo_pkg::*;

    pair_word_t mem [RAM_WORDS];
    logic       do_write;
    logic       do_read;

    assign do_write = !ram_req.cen && !ram_req.wen;
    assign do_read  = !ram_req.cen && ram_req.wen;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[ram_req.addr] <= ram_req.wdata;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (do_read) begin
            rdata <= mem[ram_req.addr];
        end
    end

endmodule

/* design/ram_pointer_ctrl.sv */
// RAM pointers, transfer arbitration and panic for the RAM backed FIFO
// capacity is clamped to the RAM size and should only change while empty or
// together with a flush
`timescale 1ns/1ps

module ram_pointer_ctrl (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 flush,
    input  logic [ram_fifo_pkg::CAP_W-1:0]       capacity,
    input  logic [ram_fifo_pkg::STAGE_LVL_W-1:0] stage_level,
    input  logic [ram_fifo_pkg::OUT_LVL_W-1:0]   out_level,
    input  ram_fifo_pkg::pair_word_t             oldest_pair,
    input  logic                                 offer_refused,
    output logic                                 bypass_pop,
    output logic                                 pair_pop,
    output logic                                 pair_load,
    output ram_fifo_pkg::ram_req_t               ram_req,
    output logic [ram_fifo_pkg::CAP_W-1:0]       count,
    output logic                                 ram_full,
    output logic                                 panic
);
    import ram_fifo_pkg::*;

    logic [CAP_W-1:0]  half_cap;
    logic [CAP_W-1:0]  pair_cap;
    logic [CAP_W-1:0]  last_idx;
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic              wr_wrap;
    logic              rd_wrap;
    logic              wr_at_end;
    logic              rd_at_end;
    logic              ram_empty;
    logic              out_full;
    logic              rd_sel;
    logic              wr_sel;
    logic              panic_now;

    // pairs in RAM, odd capacity rounds up
    assign half_cap = (capacity >> 1) + CAP_W'(capacity[0]);
    assign pair_cap = (half_cap > CAP_W'(RAM_WORDS)) ? CAP_W'(RAM_WORDS) : half_cap;
    assign last_idx = pair_cap - 1'b1;

    assign wr_at_end = (CAP_W'(wr_ptr) == last_idx);
    assign rd_at_end = (CAP_W'(rd_ptr) == last_idx);

    // wrap flags tell a full ring from an empty one
    assign count = (wr_wrap == rd_wrap) ?
                   CAP_W'(wr_ptr) - CAP_W'(rd_ptr) :
                   pair_cap - CAP_W'(rd_ptr) + CAP_W'(wr_ptr);

    assign ram_empty = (count == '0);
    assign ram_full  = (count >= pair_cap);
    assign out_full  = (out_level == OUT_LVL_W'(OUT_DEPTH));

    // read first, but not while the previous read is landing
    // since out_level does not show that pair yet
    assign rd_sel = !ram_empty && (out_level < OUT_LVL_W'(OUT_DEPTH - 1)) && !pair_load;

    // once the RAM holds data every pair goes through it to keep order
    assign wr_sel = (stage_level >= STAGE_LVL_W'(2)) && !ram_full && !rd_sel &&
                    (out_full || !ram_empty);

    assign bypass_pop = ram_empty && (stage_level != '0) && !out_full && !pair_load;
    assign pair_pop   = wr_sel;

    always_comb begin
        ram_req.cen   = !(rd_sel || wr_sel);
        ram_req.wen   = !wr_sel;
        ram_req.addr  = wr_sel ? wr_ptr : rd_ptr;
        ram_req.wdata = oldest_pair;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            wr_wrap <= 1'b0;
            rd_wrap <= 1'b0;
        end else if (flush) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            wr_wrap <= 1'b0;
            rd_wrap <= 1'b0;
        end else begin
            if (wr_sel) begin
                wr_ptr  <= wr_at_end ? '0 : wr_ptr + 1'b1;
                wr_wrap <= wr_wrap ^ wr_at_end;
            end
            if (rd_sel) begin
                rd_ptr  <= rd_at_end ? '0 : rd_ptr + 1'b1;
                rd_wrap <= rd_wrap ^ rd_at_end;
            end
        end
    end

    // one cycle RAM latency, flush drops the pair in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_load <= 1'b0;
        end else if (flush) begin
            pair_load <= 1'b0;
        end else begin
            pair_load <= rd_sel;
        end
    end

    assign panic_now = offer_refused ||
                       (pair_load && (out_level > OUT_LVL_W'(OUT_DEPTH - 2))) ||
                       (bypass_pop && pair_load) ||
                       (bypass_pop && wr_sel);

    // sticky until reset or flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            panic <= 1'b0;
        end else if (flush) begin
            panic <= 1'b0;
        end else if (panic_now) begin
            panic <= 1'b1;
        end
    end

    // an overrun of the ring would show up as a count above the pair capacity
    a_count_limit: assert property (
        @(posedge clk) disable iff (!rst_n || flush)
        count <= pair_cap
    );

endmodule

/* design/stage_out_buffer.sv */
// four word output buffer in front of the reader
// takes one bypass word or one RAM pair per cycle, never both
// data_out reads as zero while empty
`timescale 1ns/1ps

module stage_out_buffer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,
    input  logic                                bypass_load,
    input  logic [ram_fifo_pkg::DATA_W-1:0]     bypass_data,
    input  logic                                pair_load,
    input  ram_fifo_pkg::pair_word_t            pair_data,
    input  logic                                rd_en,
    output logic [ram_fifo_pkg::DATA_W-1:0]     data_out,
    output logic [ram_fifo_pkg::OUT_LVL_W-1:0]  level,
    output logic                                empty
);
    import ram_fifo_pkg::*;

    logic [DATA_W-1:0]    mem [OUT_DEPTH];
    logic [OUT_LVL_W-1:0] wr_ptr;
    logic [OUT_LVL_W-1:0] rd_ptr;
    logic [OUT_LVL_W-2:0] wr_idx;
    logic [OUT_LVL_W-2:0] wr_idx_next;
    logic                 pop;

    assign wr_idx      = wr_ptr[OUT_LVL_W-2:0];
    assign wr_idx_next = wr_idx + 1'b1;

    assign level = wr_ptr - rd_ptr;
    assign empty = (level == '0);
    assign pop   = rd_en && !empty;

    // head is read combinationally
    assign data_out = empty ? '0 : mem[rd_ptr[OUT_LVL_W-2:0]];

    always_ff @(posedge clk) begin
        if (pair_load) begin
            // older word of the pair lands first
            mem[wr_idx]      <= pair_data.lo;
            mem[wr_idx_next] <= pair_data.hi;
        end else if (bypass_load) begin
            mem[wr_idx] <= bypass_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (pair_load) begin
                wr_ptr <= wr_ptr + 2'd2;
            end else if (bypass_load) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // the read was issued a cycle earlier on a lower level,
    // so two slots must still be free when the pair lands
    a_pair_room: assert property (
        @(posedge clk) disable iff (!rst_n)
        pair_load |-> (level <= OUT_LVL_W'(OUT_DEPTH - 2))
    );

endmodule

/* design/stage_in_buffer.sv */
// eight word input staging buffer, pops one or two words per cycle
// push must only be raised while in_full is low
`timescale 1ns/1ps

module stage_in_buffer (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               flush,
    input  logic                               push,
    input  logic [ram_fifo_pkg::DATA_W-1:0]    push_data,
    input  logic                               bypass_pop,
    input  logic                               pair_pop,
    output ram_fifo_pkg::pair_word_t           oldest_pair,
    output logic [ram_fifo_pkg::STAGE_LVL_W-1:0] level,
    output logic                               in_full
);
    import ram_fifo_pkg::*;

    logic [DATA_W-1:0]      mem [STAGE_DEPTH];
    // msb of each pointer is the wrap bit
    logic [STAGE_LVL_W-1:0] wr_ptr;
    logic [STAGE_LVL_W-1:0] rd_ptr;
    logic [STAGE_LVL_W-2:0] rd_idx;
    logic [STAGE_LVL_W-2:0] rd_idx_next;

    assign rd_idx      = rd_ptr[STAGE_LVL_W-2:0];
    assign rd_idx_next = rd_idx + 1'b1;

    assign level   = wr_ptr - rd_ptr;
    assign in_full = (level == STAGE_LVL_W'(STAGE_DEPTH));

    // oldest word goes to lo, as in the RAM pair layout
    assign oldest_pair.lo = mem[rd_idx];
    assign oldest_pair.hi = mem[rd_idx_next];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[STAGE_LVL_W-2:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pair_pop) begin
                rd_ptr <= rd_ptr + 2'd2;
            end else if (bypass_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // controller may only take a pair that is fully staged
    a_pair_pop_level: assert property (
        @(posedge clk) disable iff (!rst_n)
        pair_pop |-> (level >= STAGE_LVL_W'(2))
    );

endmodule

/* design/ram_fifo_pkg.sv */
// shared widths and structs for the RAM backed FIFO
// RAM_WORDS must stay a power of two so that ADDR_W covers it exactly
package ram_fifo_pkg;

    // one FIFO data word
    localparam int DATA_W = 32;

    // pair words in the external RAM
    localparam int RAM_WORDS = 512;
    localparam int ADDR_W    = $clog2(RAM_WORDS);

    // capacity input and count output
    localparam int CAP_W = 16;

    // input staging buffer, level needs one extra bit to show full
    localparam int STAGE_DEPTH = 8;
    localparam int STAGE_LVL_W = $clog2(STAGE_DEPTH) + 1;

    // output buffer in front of the reader
    localparam int OUT_DEPTH = 4;
    localparam int OUT_LVL_W = $clog2(OUT_DEPTH) + 1;

    // two data words per RAM word, lo is the older one
    typedef struct packed {
        logic [DATA_W-1:0] hi;
        logic [DATA_W-1:0] lo;
    } pair_word_t;

    // request to the single-port RAM
    // cen and wen are active low as on the macro
    typedef struct packed {
        logic              cen;
        logic              wen;
        logic [ADDR_W-1:0] addr;
        pair_word_t        wdata;
    } ram_req_t;

endpackage
